// ==== source/clock_mode_pkg.sv ====
package clock_mode_pkg;

    // operating mode of the clock core
    typedef enum logic [2:0] {
        time_show = 3'd0,  // plain time display
        time_set  = 3'd1,  // hours/minutes being edited
        timer     = 3'd2,
        stopwatch = 3'd3,
        alarm     = 3'd4
    } clock_mode_e;

    // which field the user is editing
    // time_set uses all four values, timer and alarm only 0 and 1
    typedef logic [1:0] edit_place_t;

    // everything the display needs to know about the clock core
    typedef struct packed {
        clock_mode_e mode;               // [7:5]
        edit_place_t edit_place;         // [4:3]
        logic        timer_running;      // [2]
        logic        stopwatch_running;  // [1]
        logic        alarm_armed;        // [0]
    } clock_status_t;

endpackage

// ==== source/display_pkg.sv ====
package display_pkg;

    localparam int NUM_DIGITS = 4;

    typedef logic [3:0] bcd_t;  // one decimal digit

    // digit 0 is the rightmost on the board
    typedef struct packed {
        bcd_t thousands;  // digit 3
        bcd_t hundreds;   // digit 2
        bcd_t tens;       // digit 1
        bcd_t ones;       // digit 0
    } digit_set_t;

    typedef logic [$clog2(NUM_DIGITS)-1:0] digit_idx_t;  // scan position
    typedef logic [NUM_DIGITS-1:0] digit_mask_t;         // bit i is digit i

    // segment bus, index 0 is segment a, low lights the segment
    typedef logic [0:6] seg_t;

    // digit enables of the common-anode display, low selects a digit
    typedef logic [NUM_DIGITS-1:0] anode_t;

    localparam seg_t   SEG_BLANK = 7'b111_1111;  // all segments dark
    localparam anode_t ANODE_OFF = '1;           // no digit driven

    // abcdefg patterns for 0 to 9
    localparam seg_t SEG_DIGIT [10] = '{
        7'b000_0001,  // 0
        7'b100_1111,  // 1
        7'b001_0010,  // 2
        7'b000_0110,  // 3
        7'b100_1100,  // 4
        7'b010_0100,  // 5
        7'b010_0000,  // 6
        7'b000_1111,  // 7
        7'b000_0000,  // 8
        7'b000_0100   // 9
    };

endpackage

// ==== source/blink_select.sv ====
`timescale 1ns/1ps

module blink_select
    import clock_mode_pkg::*, display_pkg::*;
(
    input  clock_status_t status,
    output digit_mask_t   blink_mask
);

    localparam digit_mask_t LOW_PAIR  = digit_mask_t'(4'b0011);  // digits 0 and 1
    localparam digit_mask_t HIGH_PAIR = digit_mask_t'(4'b1100);  // digits 2 and 3
    localparam digit_mask_t ALL_DIGITS = '1;

    // timer and alarm only have two editable fields
    function automatic digit_mask_t two_field_pair(input edit_place_t place);
        digit_mask_t mask;
        case (place)
            2'd0:    mask = LOW_PAIR;
            2'd1:    mask = HIGH_PAIR;
            default: mask = '0;
        endcase
        return mask;
    endfunction

    always_comb begin
        blink_mask = '0;  // time_show and unknown modes
        case (status.mode)
            time_set: begin
                // 0/2 are the low fields, 1/3 the high ones
                if (status.edit_place[0]) begin
                    blink_mask = HIGH_PAIR;
                end else begin
                    blink_mask = LOW_PAIR;
                end
            end
            timer: begin
                if (!status.timer_running) begin  // only editable while stopped
                    blink_mask = two_field_pair(status.edit_place);
                end
            end
            stopwatch: begin
                if (!status.stopwatch_running) begin
                    blink_mask = ALL_DIGITS;  // whole readout blinks when halted
                end
            end
            alarm: begin
                if (!status.alarm_armed) begin
                    blink_mask = two_field_pair(status.edit_place);
                end
            end
            default: begin
                blink_mask = '0;
            end
        endcase
    end

endmodule

// ==== source/digit_scanner.sv ====
`timescale 1ns/1ps

module digit_scanner
    import display_pkg::*;
#(
    parameter int unsigned REFRESH_TICKS = 100_000,    // clocks per digit slot
    parameter int unsigned BLINK_TICKS   = 25_000_000  // clocks per blink half-period
) (
    input  logic       clk_100MHz,
    input  logic       reset,
    output digit_idx_t digit_idx,
    output logic       blink_on
);

    // +1 keeps the width at least one bit for tiny tick counts
    localparam int REFRESH_W = $clog2(REFRESH_TICKS + 1);
    localparam int BLINK_W   = $clog2(BLINK_TICKS + 1);

    localparam logic [REFRESH_W-1:0] REFRESH_LAST = REFRESH_W'(REFRESH_TICKS - 1);
    localparam logic [BLINK_W-1:0]   BLINK_LAST   = BLINK_W'(BLINK_TICKS - 1);

    logic [REFRESH_W-1:0] refresh_count;
    logic [BLINK_W-1:0]   blink_count;
    logic                 refresh_wrap;
    logic                 blink_wrap;

    assign refresh_wrap = (refresh_count == REFRESH_LAST);
    assign blink_wrap   = (blink_count == BLINK_LAST);

    // digit refresh timer
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            refresh_count <= '0;
        end else if (refresh_wrap) begin
            refresh_count <= '0;
        end else begin
            refresh_count <= refresh_count + 1'b1;
        end
    end

    // scan index, 3 rolls over to 0
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            digit_idx <= '0;
        end else if (refresh_wrap) begin
            digit_idx <= digit_idx + 1'b1;
        end
    end

    // blink timer runs free of the scan
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            blink_count <= '0;
        end else if (blink_wrap) begin
            blink_count <= '0;
        end else begin
            blink_count <= blink_count + 1'b1;
        end
    end

    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            blink_on <= 1'b0;  // starts in the dark half
        end else if (blink_wrap) begin
            blink_on <= ~blink_on;
        end
    end

endmodule

// ==== source/segment_encoder.sv ====
`timescale 1ns/1ps

module segment_encoder
    import display_pkg::*;
(
    input  logic        clk_100MHz,
    input  logic        reset,
    input  digit_set_t  digits,
    input  digit_idx_t  digit_idx,
    input  digit_mask_t blink_mask,
    input  logic        blink_on,
    output seg_t        seg,
    output anode_t      digit
);

    bcd_t   bcd;         // value of the scanned digit
    logic   blanked;
    seg_t   seg_next;
    anode_t anode_next;

    // pick the field for the current slot
    always_comb begin
        case (digit_idx)
            2'd0:    bcd = digits.ones;
            2'd1:    bcd = digits.tens;
            2'd2:    bcd = digits.hundreds;
            default: bcd = digits.thousands;
        endcase
    end

    // edited digits go dark during the off half of the blink
    assign blanked = blink_mask[digit_idx] && !blink_on;

    always_comb begin
        if (blanked) begin
            seg_next = SEG_BLANK;
        end else if (bcd > 4'd9) begin
            seg_next = SEG_BLANK;  // not a decimal code
        end else begin
            seg_next = SEG_DIGIT[bcd];
        end
    end

    // one-cold enable, bit i low for slot i
    assign anode_next = ~(anode_t'(1) << digit_idx);

    // both buses switch on the same edge so no ghosting between digits
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            seg   <= SEG_BLANK;
            digit <= ANODE_OFF;
        end else begin
            seg   <= seg_next;
            digit <= anode_next;
        end
    end

endmodule

// ==== source/seven_seg.sv ====
`timescale 1ns/1ps

module seven_seg
    import clock_mode_pkg::*, display_pkg::*;
#(
    parameter int unsigned REFRESH_TICKS = 100_000,    // 1 ms per digit at 100 MHz
    parameter int unsigned BLINK_TICKS   = 25_000_000  // 0.25 s per blink level
) (
    input  logic          clk_100MHz,
    input  logic          reset,
    input  clock_status_t status,
    input  digit_set_t    digits,
    output seg_t          seg,
    output anode_t        digit
);

    digit_mask_t blink_mask;
    digit_idx_t  digit_idx;
    logic        blink_on;

    // which digits belong to the field under edit
    blink_select u_blink_select (
        .status     (status),
        .blink_mask (blink_mask)
    );

    digit_scanner #(
        .REFRESH_TICKS (REFRESH_TICKS),
        .BLINK_TICKS   (BLINK_TICKS)
    ) u_digit_scanner (
        .clk_100MHz (clk_100MHz),
        .reset      (reset),
        .digit_idx  (digit_idx),
        .blink_on   (blink_on)
    );

    // registered segment and anode drive
    segment_encoder u_segment_encoder (
        .clk_100MHz (clk_100MHz),
        .reset      (reset),
        .digits     (digits),
        .digit_idx  (digit_idx),
        .blink_mask (blink_mask),
        .blink_on   (blink_on),
        .seg        (seg),
        .digit      (digit)
    );

endmodule

// ==== verif/seven_seg_tb.sv ====
`timescale 1ns/1ps

module seven_seg_tb
    import clock_mode_pkg::*, display_pkg::*;
;

    localparam int REFRESH_TICKS  = 4;
    localparam int BLINK_TICKS    = 24;
    localparam int RESET_CYCLES   = 4;
    localparam int PHASE_CYCLES   = 4 * BLINK_TICKS;
    localparam int TIMEOUT_CYCLES = 2 * (7 * PHASE_CYCLES) + RESET_CYCLES;
    localparam int unsigned SEED  = 32'hb2b9_62d6;

    logic          clk_100MHz = 1'b0;
    logic          reset;
    clock_status_t status;
    digit_set_t    digits;
    seg_t          seg;
    anode_t        digit;

    // reference model state
    int     m_refresh;
    int     m_idx;
    int     m_blink_cnt;
    logic   m_blink_on;
    seg_t   exp_seg;
    anode_t exp_digit;

    int cycle_count = 0;
    int seg_errors = 0;
    int digit_errors = 0;

    seven_seg #(
        .REFRESH_TICKS (REFRESH_TICKS),
        .BLINK_TICKS   (BLINK_TICKS)
    ) uut (
        .clk_100MHz (clk_100MHz),
        .reset      (reset),
        .status     (status),
        .digits     (digits),
        .seg        (seg),
        .digit      (digit)
    );

    always #5 clk_100MHz = ~clk_100MHz;

    // which digits should blink for a given status
    function automatic digit_mask_t expected_mask(input clock_status_t s);
        digit_mask_t m;
        m = 4'b0000;
        if (s.mode == time_set) begin
            m = (s.edit_place inside {2'd1, 2'd3}) ? 4'b1100 : 4'b0011;
        end else if ((s.mode == timer && !s.timer_running) ||
                     (s.mode == alarm && !s.alarm_armed)) begin
            if (s.edit_place == 2'd0) begin
                m = 4'b0011;
            end else if (s.edit_place == 2'd1) begin
                m = 4'b1100;
            end
        end else if (s.mode == stopwatch && !s.stopwatch_running) begin
            m = 4'b1111;
        end
        return m;
    endfunction

    function automatic seg_t predicted_seg(input digit_set_t d, input int idx,
                                           input logic lit, input digit_mask_t mask);
        logic [15:0] flat;
        bcd_t        v;
        flat = d;
        v = flat[idx*4 +: 4];
        if (mask[idx] && !lit) begin
            return SEG_BLANK;  // off half of the blink
        end
        if (v > 4'd9) begin
            return SEG_BLANK;
        end
        return SEG_DIGIT[v];
    endfunction

    function automatic anode_t one_cold(input int idx);
        anode_t a;
        a = ANODE_OFF;
        a[idx] = 1'b0;
        return a;
    endfunction

    function automatic clock_status_t make_status(input clock_mode_e mode,
                                                  input edit_place_t place,
                                                  input logic timer_run,
                                                  input logic sw_run,
                                                  input logic armed);
        clock_status_t s;
        s.mode              = mode;
        s.edit_place        = place;
        s.timer_running     = timer_run;
        s.stopwatch_running = sw_run;
        s.alarm_armed       = armed;
        return s;
    endfunction

    function automatic digit_set_t random_digits(input logic allow_invalid);
        digit_set_t d;
        int         hi;
        hi = allow_invalid ? 15 : 9;
        d.ones      = bcd_t'($urandom_range(hi, 0));
        d.tens      = bcd_t'($urandom_range(hi, 0));
        d.hundreds  = bcd_t'($urandom_range(hi, 0));
        d.thousands = bcd_t'($urandom_range(hi, 0));
        return d;
    endfunction

    // scan and blink counters rebuilt from the timing rules
    always @(posedge clk_100MHz) begin
        if (reset) begin
            m_refresh   <= 0;
            m_idx       <= 0;
            m_blink_cnt <= 0;
            m_blink_on  <= 1'b0;
            exp_seg     <= SEG_BLANK;
            exp_digit   <= ANODE_OFF;
        end else begin
            exp_digit <= one_cold(m_idx);
            exp_seg   <= predicted_seg(digits, m_idx, m_blink_on, expected_mask(status));
            if (m_refresh == REFRESH_TICKS - 1) begin
                m_refresh <= 0;
                m_idx     <= (m_idx + 1) % NUM_DIGITS;
            end else begin
                m_refresh <= m_refresh + 1;
            end
            if (m_blink_cnt == BLINK_TICKS - 1) begin
                m_blink_cnt <= 0;
                m_blink_on  <= ~m_blink_on;
            end else begin
                m_blink_cnt <= m_blink_cnt + 1;
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk_100MHz) begin
        assert (digit === exp_digit) else begin
            $display("MISMATCH digit: got %h expected %h at cycle %0d",
                     digit, exp_digit, cycle_count);
            digit_errors = digit_errors + 1;
        end
        assert (seg === exp_seg) else begin
            $display("MISMATCH seg: got %h expected %h at cycle %0d",
                     seg, exp_seg, cycle_count);
            seg_errors = seg_errors + 1;
        end
    end

    always @(posedge clk_100MHz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // half a phase with one status, new digits every full scan
    task automatic hold_status(input clock_status_t s, input logic allow_invalid);
        int n;
        status <= s;
        for (n = 0; n < 2 * BLINK_TICKS; n++) begin
            if (n % (NUM_DIGITS * REFRESH_TICKS) == 0) begin
                digits <= random_digits(allow_invalid);
            end
            @(posedge clk_100MHz);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset  <= 1'b1;
        status <= make_status(time_show, 2'd0, 1'b0, 1'b0, 1'b0);
        digits <= '0;
        repeat (RESET_CYCLES) @(posedge clk_100MHz);
        reset <= 1'b0;

        hold_status(make_status(time_show, 2'd0, 1'b0, 1'b0, 1'b0), 1'b0);
        hold_status(make_status(time_show, 2'd2, 1'b1, 1'b0, 1'b1), 1'b0);

        hold_status(make_status(time_set, 2'd0, 1'b0, 1'b0, 1'b0), 1'b0);
        hold_status(make_status(time_set, 2'd3, 1'b0, 1'b0, 1'b0), 1'b0);

        hold_status(make_status(timer, 2'd0, 1'b0, 1'b0, 1'b0), 1'b0);  // stopped
        hold_status(make_status(timer, 2'd1, 1'b0, 1'b0, 1'b0), 1'b0);

        hold_status(make_status(alarm, 2'd0, 1'b0, 1'b0, 1'b0), 1'b0);  // disarmed
        hold_status(make_status(alarm, 2'd1, 1'b0, 1'b0, 1'b0), 1'b0);

        hold_status(make_status(timer, 2'd0, 1'b1, 1'b0, 1'b0), 1'b0);
        hold_status(make_status(alarm, 2'd1, 1'b0, 1'b0, 1'b1), 1'b0);

        hold_status(make_status(stopwatch, 2'd0, 1'b0, 1'b0, 1'b0), 1'b0);
        hold_status(make_status(stopwatch, 2'd0, 1'b0, 1'b1, 1'b0), 1'b0);

        // codes above 9 on digits that do not blink
        hold_status(make_status(time_show, 2'd0, 1'b0, 1'b0, 1'b0), 1'b1);
        hold_status(make_status(stopwatch, 2'd1, 1'b0, 1'b1, 1'b0), 1'b1);

        // last falling-edge check is done by the next rising edge
        @(posedge clk_100MHz);
        $display("seg errors: %0d, digit errors: %0d", seg_errors, digit_errors);
        if (seg_errors == 0 && digit_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/clock_mode_pkg.sv
source/display_pkg.sv
source/blink_select.sv
source/digit_scanner.sv
source/segment_encoder.sv
source/seven_seg.sv
verif/seven_seg_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module seven_seg_tb -o seven_seg_sim || exit 1

out=$(./obj_dir/seven_seg_sim) && printf '%s\n' "$out" || { printf '%s\n' "$out"; exit 1; }

printf '%s\n' "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
